// ==== vlog.f ====
hdl/blocfifo_pkg.sv
hdl/blocfifo_ram.sv
hdl/blocfifo_wr_ctrl.sv
hdl/blocfifo_rd_decode.sv
hdl/blocfifo_segm_exec.sv
hdl/blocfifo_rd_result.sv
hdl/blocfifo_top.sv
bench/tb_clkgen.sv
bench/tb_blocfifo.sv

// ==== Makefile ====
TOP := tb_blocfifo

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf obj_dir

// ==== bench/tb_blocfifo.sv ====
// block FIFO testbench, queue model of complete blocks with profile read order and checks
`timescale 1ns/1ns
`default_nettype none

module tb_blocfifo;

  import blocfifo_pkg::*;

  localparam int DATA_WIDTH = 8;
  localparam int BLOCK_LEN  = 16;
  localparam int BLOCK_QTY  = 4;
  localparam int IDX_W      = $clog2(BLOCK_LEN);
  localparam int DRAIN_MAX  = 20;  // cycles allowed for the output to settle

  typedef struct packed {
    logic                  valid;
    logic                  sop;
    logic                  eop;
    logic [IDX_W-1:0]      index;
    logic [DATA_WIDTH-1:0] data;
  } exp_beat_t;

  logic clk_rd;
  logic rst_n;
  logic din_restart;
  logic din_valid;
  logic [DATA_WIDTH-1:0] din_data;
  prof_sel_e prof_sel;
  logic dout_drop;
  logic dout_restart;
  logic dout_request;
  logic din_ready;
  logic bloc_full;
  logic bloc_empty;
  logic overflow;
  logic underflow;
  logic dout_sop;
  logic dout_eop;
  logic dout_valid;
  logic [DATA_WIDTH-1:0] dout_data;
  logic [IDX_W-1:0] dout_index;

  exp_beat_t exp_now;                   // beat predicted for this cycle's read op
  exp_beat_t exp_d1;                    // memory read stage
  exp_beat_t exp_d2;                    // lines up with the DUT output
  int        model_used;                // complete blocks not yet freed
  int        add_blk;                   // blocks completed at the coming edge
  int        sub_blk;                   // blocks freed at the coming edge
  logic      exp_ovf;
  logic      exp_udf;
  logic [DATA_WIDTH-1:0] blk_q[$];      // complete blocks, back to back
  logic [DATA_WIDTH-1:0] part [BLOCK_LEN];
  int        part_cnt = 0;              // words in partial write block
  int        rd_pos = 0;                // position in read order of front block
  logic [15:0] lfsr_q = 16'd9;
  int        err_cnt = 0;
  int        test_cnt = 0;
  int        bad_cnt = 0;
  int        test_err0 = 0;
  string     test_name;
  logic      timed_out = 1'b0;

  tb_clkgen #(.PERIOD_NS(10), .RESET_CYCLES(8)) u_clkgen (.clk_rd(clk_rd), .rst_n(rst_n));

  blocfifo_top #(.DATA_WIDTH(DATA_WIDTH), .BLOCK_LEN(BLOCK_LEN), .BLOCK_QTY(BLOCK_QTY)) uut (
    .clk_rd(clk_rd), .rst_n(rst_n), .din_restart(din_restart), .din_valid(din_valid),
    .din_data(din_data), .prof_sel(prof_sel), .dout_drop(dout_drop),
    .dout_restart(dout_restart), .dout_request(dout_request), .din_ready(din_ready),
    .bloc_full(bloc_full), .bloc_empty(bloc_empty), .overflow(overflow),
    .underflow(underflow), .dout_sop(dout_sop), .dout_eop(dout_eop),
    .dout_valid(dout_valid), .dout_data(dout_data), .dout_index(dout_index));

  // expected pipeline and occupancy, same edges as the DUT
  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      exp_d1     <= '0;
      exp_d2     <= '0;
      model_used <= 0;
      exp_ovf    <= 1'b0;
      exp_udf    <= 1'b0;
    end else begin
      exp_d1     <= exp_now;
      exp_d2     <= exp_d1;
      model_used <= model_used + add_blk - sub_blk;
      exp_ovf    <= din_valid && (model_used == BLOCK_QTY);  // word refused
      exp_udf    <= dout_request && (model_used == 0);       // nothing to read
    end
  end

  chk_valid : assert property (@(posedge clk_rd) disable iff (!rst_n)
    dout_valid == exp_d2.valid) else begin
    err_cnt++;
    $display("Mismatch at %0t: dout_valid got %b expected %b", $time,
             $sampled(dout_valid), $sampled(exp_d2.valid));
  end
  chk_eop : assert property (@(posedge clk_rd) disable iff (!rst_n)
    dout_eop == exp_d2.eop) else begin
    err_cnt++;
    $display("Mismatch at %0t: dout_eop got %b expected %b", $time,
             $sampled(dout_eop), $sampled(exp_d2.eop));
  end
  chk_sop : assert property (@(posedge clk_rd) disable iff (!rst_n)
    exp_d2.valid |-> dout_sop == exp_d2.sop) else begin
    err_cnt++;
    $display("Mismatch at %0t: dout_sop got %b expected %b", $time,
             $sampled(dout_sop), $sampled(exp_d2.sop));
  end
  chk_data : assert property (@(posedge clk_rd) disable iff (!rst_n)
    exp_d2.valid |-> dout_data == exp_d2.data) else begin
    err_cnt++;
    $display("Mismatch at %0t: dout_data got %h expected %h", $time,
             $sampled(dout_data), $sampled(exp_d2.data));
  end
  chk_index : assert property (@(posedge clk_rd) disable iff (!rst_n)
    exp_d2.valid |-> dout_index == exp_d2.index) else begin
    err_cnt++;
    $display("Mismatch at %0t: dout_index got %0d expected %0d", $time,
             $sampled(dout_index), $sampled(exp_d2.index));
  end
  chk_ready : assert property (@(posedge clk_rd) disable iff (!rst_n)
    din_ready == (model_used < BLOCK_QTY)) else begin
    err_cnt++;
    $display("Mismatch at %0t: din_ready got %b expected %b", $time,
             $sampled(din_ready), $sampled(model_used < BLOCK_QTY));
  end
  chk_full : assert property (@(posedge clk_rd) disable iff (!rst_n)
    bloc_full == (model_used == BLOCK_QTY)) else begin
    err_cnt++;
    $display("Mismatch at %0t: bloc_full got %b expected %b", $time,
             $sampled(bloc_full), $sampled(model_used == BLOCK_QTY));
  end
  chk_empty : assert property (@(posedge clk_rd) disable iff (!rst_n)
    bloc_empty == (model_used == 0)) else begin
    err_cnt++;
    $display("Mismatch at %0t: bloc_empty got %b expected %b", $time,
             $sampled(bloc_empty), $sampled(model_used == 0));
  end
  chk_ovf : assert property (@(posedge clk_rd) disable iff (!rst_n)
    overflow == exp_ovf) else begin
    err_cnt++;
    $display("Mismatch at %0t: overflow got %b expected %b", $time,
             $sampled(overflow), $sampled(exp_ovf));
  end
  chk_udf : assert property (@(posedge clk_rd) disable iff (!rst_n)
    underflow == exp_udf) else begin
    err_cnt++;
    $display("Mismatch at %0t: underflow got %b expected %b", $time,
             $sampled(underflow), $sampled(exp_udf));
  end

  // x^16 + x^14 + x^13 + x^11 + 1, shift left
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [DATA_WIDTH-1:0] rand_word();
    logic [DATA_WIDTH-1:0] w;
    w = '0;
    for (int i = 0; i < DATA_WIDTH; i++) begin
      lfsr_q = lfsr_step(lfsr_q);  // one step per bit
      w = {w[DATA_WIDTH-2:0], lfsr_q[0]};
    end
    return w;
  endfunction

  // word offset of the pos-th read in a block
  function automatic int read_offset(prof_sel_e prof, int pos);
    if (prof == PROF_FOLD) begin
      if (pos < BLOCK_LEN / 2) begin
        return BLOCK_LEN - 1 - pos;  // upper half, top down
      end
      return pos - BLOCK_LEN / 2;    // then lower half up
    end
    return pos;
  endfunction

  function automatic void clear_inputs();
    din_restart  = 1'b0;
    din_valid    = 1'b0;
    din_data     = '0;
    dout_drop    = 1'b0;
    dout_restart = 1'b0;
    dout_request = 1'b0;
    exp_now      = '0;
    add_blk      = 0;
    sub_blk      = 0;
  endfunction

  function automatic void free_front_block();
    for (int i = 0; i < BLOCK_LEN; i++) begin
      blk_q.delete(0);
    end
    sub_blk = 1;
    rd_pos  = 0;  // next block starts over
  endfunction

  function automatic logic pipe_busy();
    return exp_now.valid || exp_now.eop || exp_d1.valid || exp_d1.eop ||
           exp_d2.valid || exp_d2.eop || dout_valid || dout_eop;
  endfunction

  task automatic write_word(input logic restart);
    @(negedge clk_rd);
    clear_inputs();
    din_valid   = 1'b1;
    din_data    = rand_word();
    din_restart = restart;
    if (restart) begin
      part_cnt = 0;  // partial block forgotten, word not taken
    end else if (model_used < BLOCK_QTY) begin
      part[part_cnt] = din_data;
      part_cnt++;
      if (part_cnt == BLOCK_LEN) begin
        for (int i = 0; i < BLOCK_LEN; i++) begin
          blk_q.push_back(part[i]);
        end
        part_cnt = 0;
        add_blk  = 1;
      end
    end
  endtask

  task automatic write_blocks(input int n);
    repeat (n * BLOCK_LEN) write_word(1'b0);
  endtask

  task automatic read_step();
    int off;
    @(negedge clk_rd);
    clear_inputs();
    dout_request = 1'b1;
    if (model_used > 0) begin
      off           = read_offset(prof_sel, rd_pos);
      exp_now.valid = 1'b1;
      exp_now.sop   = (rd_pos == 0);
      exp_now.eop   = (rd_pos == BLOCK_LEN - 1);
      exp_now.index = IDX_W'(rd_pos);
      exp_now.data  = blk_q[off];
      if (rd_pos == BLOCK_LEN - 1) begin
        free_front_block();
      end else begin
        rd_pos++;
      end
    end
  endtask

  task automatic read_words(input int n);
    repeat (n) read_step();
  endtask

  task automatic read_restart();
    @(negedge clk_rd);
    clear_inputs();
    dout_restart = 1'b1;
    if (model_used > 0) begin
      rd_pos = 0;  // same block from sop
    end
  endtask

  task automatic read_drop();
    @(negedge clk_rd);
    clear_inputs();
    dout_drop = 1'b1;
    if (model_used > 0) begin
      exp_now.eop = 1'b1;  // marker beat, valid low
      free_front_block();
    end
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (pipe_busy() && n < DRAIN_MAX) begin
      @(negedge clk_rd);
      clear_inputs();
      n++;
    end
    if (pipe_busy()) begin
      timed_out = 1'b1;
      $display("timeout: output did not go idle within %0d cycles in %s", DRAIN_MAX, test_name);
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_err0 = err_cnt;
    test_cnt++;
  endtask

  task automatic end_test();
    wait_drained();
    repeat (2) begin  // let flag checks see the settled count
      @(negedge clk_rd);
      clear_inputs();
    end
    if (err_cnt != test_err0 || timed_out) begin
      bad_cnt++;
    end
    $display("test %0d %s: %0d errors", test_cnt, test_name, err_cnt - test_err0);
  endtask

  initial begin
    int n;
    clear_inputs();
    prof_sel = PROF_LINEAR;
    n = 0;
    while (!rst_n && n < 50) begin
      @(negedge clk_rd);
      n++;
    end
    if (!rst_n) begin
      timed_out = 1'b1;
      $display("timeout: reset was never released");
    end
    if (!timed_out) begin
      begin_test("linear readout");
      write_blocks(2);
      read_words(2 * BLOCK_LEN);
      end_test();
    end
    if (!timed_out) begin
      begin_test("fold readout");
      write_blocks(1);
      prof_sel = PROF_FOLD;  // front block not started yet
      read_words(BLOCK_LEN);
      end_test();
      prof_sel = PROF_LINEAR;
    end
    if (!timed_out) begin
      begin_test("full and overflow");
      write_blocks(BLOCK_QTY);
      repeat (4) write_word(1'b0);  // refused while full
      read_words(BLOCK_QTY * BLOCK_LEN);
      end_test();
    end
    if (!timed_out) begin
      begin_test("empty and underflow");
      read_words(4);
      read_restart();
      read_drop();  // ignored while empty
      read_words(2);
      end_test();
    end
    if (!timed_out) begin
      begin_test("restarts");
      write_blocks(1);
      repeat (5) write_word(1'b0);
      write_word(1'b1);  // partial block thrown away
      write_blocks(1);
      read_words(6);
      read_restart();
      read_words(2 * BLOCK_LEN);
      end_test();
    end
    if (!timed_out) begin
      begin_test("drop");
      write_blocks(BLOCK_QTY);
      read_words(5);
      read_drop();  // bloc_full clears one edge later
      read_words((BLOCK_QTY - 1) * BLOCK_LEN);
      end_test();
    end
    $display("tests %0d, tests with errors %0d, errors %0d", test_cnt, bad_cnt, err_cnt);
    if (err_cnt == 0 && bad_cnt == 0 && !timed_out) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/tb_clkgen.sv ====
// testbench clock and reset source, free running clock and reset held for a few cycles
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD_NS    = 10,  // full clock period
  parameter int RESET_CYCLES = 8    // cycles with reset low
) (
  output logic clk_rd,
  output logic rst_n
);

  initial begin
    clk_rd = 1'b0;
    forever #(PERIOD_NS / 2) clk_rd = ~clk_rd;
  end

  initial begin
    rst_n = 1'b0;  // low from time 0
    repeat (RESET_CYCLES) @(posedge clk_rd);
    @(negedge clk_rd);
    rst_n = 1'b1;  // released away from the active edge
  end

endmodule

`default_nettype wire

// ==== hdl/blocfifo_top.sv ====
// block FIFO top, write sequencer, read decode and execute, output stage and block memory
`timescale 1ns/1ns
`default_nettype none

module blocfifo_top #(
  parameter int DATA_WIDTH = 8,   // word width, same on both sides
  parameter int BLOCK_LEN  = 16,  // words per block, even
  parameter int BLOCK_QTY  = 4    // blocks in the ring
) (
  input  wire logic                        clk_rd,        // single clock
  input  wire logic                        rst_n,         // async, active low
  input  wire logic                        din_restart,   // drop partial write block
  input  wire logic                        din_valid,     // input word present
  input  wire logic [DATA_WIDTH-1:0]       din_data,
  input  wire blocfifo_pkg::prof_sel_e     prof_sel,      // read order profile
  input  wire logic                        dout_drop,     // free block being read
  input  wire logic                        dout_restart,  // reread current block
  input  wire logic                        dout_request,  // one word wanted
  output logic                             din_ready,
  output logic                             bloc_full,
  output logic                             bloc_empty,
  output logic                             overflow,      // write while not ready
  output logic                             underflow,     // request while empty
  output logic                             dout_sop,
  output logic                             dout_eop,
  output logic                             dout_valid,
  output logic [DATA_WIDTH-1:0]            dout_data,
  output logic [$clog2(BLOCK_LEN)-1:0]     dout_index
);

  import blocfifo_pkg::*;

  localparam int DEPTH  = BLOCK_LEN * BLOCK_QTY;  // total words stored
  localparam int ADDR_W = $clog2(DEPTH);

  logic              mem_wr_en;
  logic [ADDR_W-1:0] mem_wr_addr;
  logic [ADDR_W-1:0] mem_rd_addr;
  logic [DATA_WIDTH-1:0] mem_rd_data;
  logic              bloc_done;  // write side finished a block
  logic              bloc_free;  // read side released a block
  rd_op_e            rd_op;      // one read action per cycle
  rd_beat_t          beat;       // beat flags, memory address cycle

  blocfifo_wr_ctrl #(.BLOCK_LEN(BLOCK_LEN), .BLOCK_QTY(BLOCK_QTY)) u_wr_ctrl (
    .clk_rd(clk_rd), .rst_n(rst_n), .din_restart(din_restart), .din_valid(din_valid),
    .din_ready(din_ready), .mem_wr_en(mem_wr_en), .mem_wr_addr(mem_wr_addr),
    .bloc_done(bloc_done));

  blocfifo_rd_decode #(.BLOCK_QTY(BLOCK_QTY)) u_rd_decode (
    .clk_rd(clk_rd), .rst_n(rst_n), .din_valid(din_valid), .bloc_done(bloc_done),
    .bloc_free(bloc_free), .dout_drop(dout_drop), .dout_restart(dout_restart),
    .dout_request(dout_request), .rd_op(rd_op), .din_ready(din_ready),
    .bloc_full(bloc_full), .bloc_empty(bloc_empty), .overflow(overflow),
    .underflow(underflow));

  blocfifo_segm_exec #(.BLOCK_LEN(BLOCK_LEN), .BLOCK_QTY(BLOCK_QTY)) u_segm_exec (
    .clk_rd(clk_rd), .rst_n(rst_n), .rd_op(rd_op), .prof_sel(prof_sel),
    .mem_rd_addr(mem_rd_addr), .beat(beat), .bloc_free(bloc_free));

  blocfifo_rd_result #(.DATA_WIDTH(DATA_WIDTH), .BLOCK_LEN(BLOCK_LEN)) u_rd_result (
    .clk_rd(clk_rd), .rst_n(rst_n), .beat(beat), .mem_rd_data(mem_rd_data),
    .dout_valid(dout_valid), .dout_sop(dout_sop), .dout_eop(dout_eop),
    .dout_data(dout_data), .dout_index(dout_index));

  blocfifo_ram #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(DEPTH)) u_ram (
    .clk_rd(clk_rd), .wr_en(mem_wr_en), .wr_addr(mem_wr_addr), .wr_data(din_data),
    .rd_addr(mem_rd_addr), .rd_data(mem_rd_data));

endmodule

`default_nettype wire

// ==== hdl/blocfifo_rd_result.sv ====
// block FIFO output stage, aligns beat flags with memory latency and counts the word index
`timescale 1ns/1ns
`default_nettype none

module blocfifo_rd_result #(
  parameter int DATA_WIDTH = 8,   // word width
  parameter int BLOCK_LEN  = 16   // words per block
) (
  input  wire logic                      clk_rd,
  input  wire logic                      rst_n,
  input  wire blocfifo_pkg::rd_beat_t    beat,         // address cycle flags
  input  wire logic [DATA_WIDTH-1:0]     mem_rd_data,  // one cycle after address
  output logic                           dout_valid,
  output logic                           dout_sop,
  output logic                           dout_eop,
  output logic [DATA_WIDTH-1:0]          dout_data,
  output logic [$clog2(BLOCK_LEN)-1:0]   dout_index
);

  import blocfifo_pkg::*;

  rd_beat_t beat_d;  // lines up with mem_rd_data

  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      beat_d     <= '0;
      dout_valid <= 1'b0;
      dout_sop   <= 1'b0;
      dout_eop   <= 1'b0;
      dout_index <= '0;
    end else begin
      beat_d     <= beat;
      dout_valid <= beat_d.valid;
      dout_sop   <= beat_d.sop;
      dout_eop   <= beat_d.eop;
      if (beat_d.sop || dout_eop) begin
        dout_index <= '0;  // new block or reread
      end else if (dout_valid) begin
        dout_index <= dout_index + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_rd) begin
    if (beat_d.valid) begin
      dout_data <= mem_rd_data;  // held between beats
    end
  end

  // only the eop beat may sit on the last index
  a_rd_index_range : assert property (@(posedge clk_rd) disable iff (!rst_n)
    dout_valid && !dout_eop |-> int'(dout_index) < BLOCK_LEN - 1);

endmodule

`default_nettype wire

// ==== hdl/blocfifo_segm_exec.sv ====
// block FIFO read execute, walks segments and offsets of the profile and the read block pointer
`timescale 1ns/1ns
`default_nettype none

module blocfifo_segm_exec #(
  parameter int BLOCK_LEN = 16,  // words per block
  parameter int BLOCK_QTY = 4    // blocks in the ring
) (
  input  wire logic                               clk_rd,
  input  wire logic                               rst_n,
  input  wire blocfifo_pkg::rd_op_e               rd_op,        // from decode
  input  wire blocfifo_pkg::prof_sel_e            prof_sel,     // live profile choice
  output logic [$clog2(BLOCK_LEN*BLOCK_QTY)-1:0]  mem_rd_addr,
  output blocfifo_pkg::rd_beat_t                  beat,         // flags of this read
  output logic                                    bloc_free     // block released
);

  import blocfifo_pkg::*;

  localparam int OFFS_W = $clog2(BLOCK_LEN);
  localparam int BLOC_W = (BLOCK_QTY > 1) ? $clog2(BLOCK_QTY) : 1;
  localparam int SEGM_W = (SEGMENT_QTY > 1) ? $clog2(SEGMENT_QTY) : 1;
  localparam int ADDR_W = $clog2(BLOCK_LEN * BLOCK_QTY);

  logic [SEGM_W-1:0] segm_q;    // segment of next read
  logic [OFFS_W-1:0] offs_q;    // offset of next read
  logic [BLOC_W-1:0] rd_bloc;   // block being read
  logic              at_start;  // next read opens the block
  logic [SEGM_W-1:0] cur_segm;
  logic [OFFS_W-1:0] cur_offs;
  logic              seg_last;  // offset at segment end
  logic              is_sop;
  logic              is_eop;
  logic              rd_step;
  logic              rd_drop;

  // block start follows prof_sel at the moment of the first read
  assign cur_segm = at_start ? '0 : segm_q;
  assign cur_offs = at_start ? OFFS_W'(segm_start(BLOCK_LEN, prof_sel, 0)) : offs_q;

  assign seg_last = (int'(cur_offs) == segm_end(BLOCK_LEN, prof_sel, int'(cur_segm)));
  assign is_eop   = seg_last & (int'(cur_segm) == SEGMENT_QTY - 1);
  assign is_sop   = (cur_segm == '0) &
                    (int'(cur_offs) == segm_start(BLOCK_LEN, prof_sel, 0));
  assign rd_step  = (rd_op == RD_STEP);
  assign rd_drop  = (rd_op == RD_DROP);

  assign bloc_free   = (rd_step & is_eop) | rd_drop;
  assign mem_rd_addr = ADDR_W'(rd_bloc) * ADDR_W'(BLOCK_LEN) + ADDR_W'(cur_offs);
  assign beat        = rd_beat_t'{valid: rd_step, sop: rd_step & is_sop,
                                  eop: (rd_step & is_eop) | rd_drop};  // drop marker

  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      at_start <= 1'b1;
      segm_q   <= '0;
      offs_q   <= '0;
      rd_bloc  <= '0;
    end else if (bloc_free) begin
      at_start <= 1'b1;  // eop read or drop
      rd_bloc  <= (rd_bloc == BLOC_W'(BLOCK_QTY - 1)) ? '0 : rd_bloc + 1'b1;
    end else if (rd_op == RD_RESTART) begin
      at_start <= 1'b1;  // same block, first segment again
    end else if (rd_step) begin
      at_start <= 1'b0;
      if (seg_last) begin
        segm_q <= cur_segm + 1'b1;  // jump to next segment start
        offs_q <= OFFS_W'(segm_start(BLOCK_LEN, prof_sel, int'(cur_segm) + 1));
      end else begin
        segm_q <= cur_segm;
        offs_q <= cur_offs + OFFS_W'(segm_step(BLOCK_LEN, prof_sel, int'(cur_segm)));
      end
    end
  end

  // profile walk never steps the offset past either end of the block
  a_rd_offs_range : assert property (@(posedge clk_rd) disable iff (!rst_n)
    rd_step && !seg_last |->
      int'(cur_offs) + segm_step(BLOCK_LEN, prof_sel, int'(cur_segm)) >= 0 &&
      int'(cur_offs) + segm_step(BLOCK_LEN, prof_sel, int'(cur_segm)) < BLOCK_LEN);

endmodule

`default_nettype wire

// ==== hdl/blocfifo_rd_decode.sv ====
// block FIFO occupancy, status flags and per-cycle read opcode decode
`timescale 1ns/1ns
`default_nettype none

module blocfifo_rd_decode #(
  parameter int BLOCK_QTY = 4  // blocks in the ring
) (
  input  wire logic            clk_rd,
  input  wire logic            rst_n,
  input  wire logic            din_valid,     // for overflow detect
  input  wire logic            bloc_done,     // +1 block used
  input  wire logic            bloc_free,     // -1 block used
  input  wire logic            dout_drop,
  input  wire logic            dout_restart,
  input  wire logic            dout_request,
  output blocfifo_pkg::rd_op_e rd_op,
  output logic                 din_ready,
  output logic                 bloc_full,
  output logic                 bloc_empty,
  output logic                 overflow,
  output logic                 underflow
);

  import blocfifo_pkg::*;

  localparam int CNT_W = $clog2(BLOCK_QTY + 1);  // holds 0..BLOCK_QTY

  logic [CNT_W-1:0] used_cnt;  // complete blocks not yet freed

  assign din_ready  = (used_cnt < CNT_W'(BLOCK_QTY));
  assign bloc_full  = (used_cnt == CNT_W'(BLOCK_QTY));
  assign bloc_empty = (used_cnt == '0);

  // drop > restart > request, nothing while empty
  always_comb begin
    if (bloc_empty) begin
      rd_op = RD_IDLE;
    end else if (dout_drop) begin
      rd_op = RD_DROP;
    end else if (dout_restart) begin
      rd_op = RD_RESTART;
    end else if (dout_request) begin
      rd_op = RD_STEP;
    end else begin
      rd_op = RD_IDLE;
    end
  end

  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      used_cnt <= '0;
    end else if (bloc_done != bloc_free) begin  // both at once cancel out
      used_cnt <= bloc_done ? used_cnt + 1'b1 : used_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      overflow  <= 1'b0;
      underflow <= 1'b0;
    end else begin
      overflow  <= din_valid & ~din_ready;     // word refused
      underflow <= dout_request & bloc_empty;  // nothing to read
    end
  end

  // write side must not finish a block with the ring already full
  a_no_fill_full : assert property (@(posedge clk_rd) disable iff (!rst_n)
    bloc_done |-> !bloc_full);

  // read side must not free a block that was never written
  a_no_free_empty : assert property (@(posedge clk_rd) disable iff (!rst_n)
    bloc_free |-> !bloc_empty);

endmodule

`default_nettype wire

// ==== hdl/blocfifo_wr_ctrl.sv ====
// block FIFO write sequencer, word offset and write block pointer into the ring
`timescale 1ns/1ns
`default_nettype none

module blocfifo_wr_ctrl #(
  parameter int BLOCK_LEN = 16,  // words per block
  parameter int BLOCK_QTY = 4    // blocks in the ring
) (
  input  wire logic                                  clk_rd,
  input  wire logic                                  rst_n,
  input  wire logic                                  din_restart,  // abandon partial block
  input  wire logic                                  din_valid,
  input  wire logic                                  din_ready,    // from occupancy count
  output logic                                       mem_wr_en,
  output logic [$clog2(BLOCK_LEN*BLOCK_QTY)-1:0]     mem_wr_addr,
  output logic                                       bloc_done     // last word of block written
);

  localparam int OFFS_W = $clog2(BLOCK_LEN);
  localparam int BLOC_W = (BLOCK_QTY > 1) ? $clog2(BLOCK_QTY) : 1;
  localparam int ADDR_W = $clog2(BLOCK_LEN * BLOCK_QTY);

  logic [OFFS_W-1:0] wr_offs;    // word offset inside block
  logic [BLOC_W-1:0] wr_bloc;    // block being filled
  logic              last_word;  // offset at block end

  assign mem_wr_en   = din_valid & din_ready & ~din_restart;  // restart wins over the word
  assign last_word   = (wr_offs == OFFS_W'(BLOCK_LEN - 1));
  assign bloc_done   = mem_wr_en & last_word;
  assign mem_wr_addr = ADDR_W'(wr_bloc) * ADDR_W'(BLOCK_LEN) + ADDR_W'(wr_offs);

  always_ff @(posedge clk_rd or negedge rst_n) begin
    if (!rst_n) begin
      wr_offs <= '0;
      wr_bloc <= '0;
    end else if (din_restart) begin
      wr_offs <= '0;  // partial words are simply overwritten later
    end else if (mem_wr_en) begin
      if (last_word) begin
        wr_offs <= '0;
        // ring wrap, modulo block count
        wr_bloc <= (wr_bloc == BLOC_W'(BLOCK_QTY - 1)) ? '0 : wr_bloc + 1'b1;
      end else begin
        wr_offs <= wr_offs + 1'b1;
      end
    end
  end

  // offset wraps at the block end, so it never reaches BLOCK_LEN
  a_wr_wrap : assert property (@(posedge clk_rd) disable iff (!rst_n)
    bloc_done |=> (wr_offs == '0) && !bloc_done);

endmodule

`default_nettype wire

// ==== hdl/blocfifo_ram.sv ====
// block FIFO storage, simple dual-port memory with registered read
`timescale 1ns/1ns
`default_nettype none

module blocfifo_ram #(
  parameter int DATA_WIDTH = 8,   // word width
  parameter int DEPTH      = 64   // words in total
) (
  input  wire logic                       clk_rd,
  input  wire logic                       wr_en,
  input  wire logic [$clog2(DEPTH)-1:0]   wr_addr,
  input  wire logic [DATA_WIDTH-1:0]      wr_data,
  input  wire logic [$clog2(DEPTH)-1:0]   rd_addr,
  output logic [DATA_WIDTH-1:0]           rd_data   // valid one cycle after rd_addr
);

  logic [DATA_WIDTH-1:0] mem [DEPTH];  // block ring storage

  always_ff @(posedge clk_rd) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge clk_rd) begin
    rd_data <= mem[rd_addr];  // read every cycle, old data on collision
  end

endmodule

`default_nettype wire

// ==== hdl/blocfifo_pkg.sv ====
// block FIFO shared types, read opcodes and the two-segment profile table
`default_nettype none

package blocfifo_pkg;

  localparam int SEGMENT_QTY = 2;  // segments per profile, fixed

  typedef enum logic [1:0] {
    RD_IDLE    = 2'd0,  // no read this cycle
    RD_STEP    = 2'd1,  // one word out of the block
    RD_RESTART = 2'd2,  // back to start of first segment
    RD_DROP    = 2'd3   // free the current block now
  } rd_op_e;

  typedef enum logic {
    PROF_LINEAR = 1'b0,  // lower half up, then upper half up
    PROF_FOLD   = 1'b1   // upper half down, then lower half up
  } prof_sel_e;

  typedef struct packed {
    logic valid;  // word carried by this beat
    logic sop;    // first word of block
    logic eop;    // last word, or drop marker when valid low
  } rd_beat_t;

  function automatic int segm_start(int block_len, prof_sel_e prof, int segm);
    if (prof == PROF_FOLD) begin
      return (segm == 0) ? block_len - 1 : 0;  // top word first
    end
    return (segm == 0) ? 0 : block_len / 2;
  endfunction

  function automatic int segm_end(int block_len, prof_sel_e prof, int segm);
    if (prof == PROF_FOLD) begin
      return (segm == 0) ? block_len / 2 : block_len / 2 - 1;
    end
    return (segm == 0) ? block_len / 2 - 1 : block_len - 1;
  endfunction

  function automatic int segm_step(int block_len, prof_sel_e prof, int segm);
    if (prof == PROF_FOLD && segm == 0 && block_len > 1) begin
      return -1;  // descending upper half
    end
    return 1;
  endfunction

endpackage

`default_nettype wire
